// File: design/fetch_pkg.sv
package fetch_pkg;

    // Address and word geometry
    localparam int WORD_SIZE     = 32;
    localparam int WORD_BYTES    = 4;
    localparam int WORD_OFF_W    = $clog2(WORD_BYTES);
    localparam int PAGE_OFFSET_W = 12;
    localparam int VPN_W         = WORD_SIZE - PAGE_OFFSET_W;

    // Cache line geometry
    localparam int LINE_WORDS  = 4;
    localparam int BEAT_W      = $clog2(LINE_WORDS);
    localparam int LINE_OFF_W  = BEAT_W + WORD_OFF_W;
    localparam int CACHE_LINES = 16;
    localparam int INDEX_W     = $clog2(CACHE_LINES);
    localparam int TAG_W       = WORD_SIZE - INDEX_W - LINE_OFF_W;

    // Translation buffer size
    localparam int TLB_ENTRIES = 4;
    localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);

    // Fixed address vectors
    localparam logic [WORD_SIZE-1:0] PC_INITIAL   = 32'h0000_1000;
    localparam logic [WORD_SIZE-1:0] PC_EXCEPTION = 32'h0000_0100; // Physical address, not translated
    localparam logic [WORD_SIZE-1:0] PT_BASE      = 32'h0008_0000;

    // Page-table entry layout with the page number in the low VPN_W bits
    localparam int PTE_VALID_BIT = 31;

    typedef enum logic {
        LEN_WORD,
        LEN_LINE
    } req_len_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SETUP,
        ARB_ACCESS
    } arb_state_e;

    typedef enum logic {
        TLB_LOOKUP,
        TLB_WALK
    } tlb_state_e;

    typedef enum logic {
        C_IDLE,
        C_REFILL
    } cache_state_e;

endpackage

// File: design/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if;
    import fetch_pkg::*;

    logic                 req;        // Held until done
    logic [WORD_SIZE-1:0] addr;       // First word address
    req_len_e             len;
    logic                 beat_valid; // One pulse per word read
    logic [WORD_SIZE-1:0] beat_data;
    logic                 beat_err;   // Bus error on this beat
    logic                 done;       // Same cycle as last beat

    modport requester (
        output req, addr, len,
        input  beat_valid, beat_data, beat_err, done
    );

    modport arbiter (
        input  req, addr, len,
        output beat_valid, beat_data, beat_err, done
    );

endinterface

// File: design/itlb.sv
`timescale 1ns/1ps

module itlb (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [fetch_pkg::VPN_W-1:0] vpn,
    input  logic                        lookup,
    mem_req_if.requester                mem,
    output logic [fetch_pkg::VPN_W-1:0] ppn,
    output logic                        hit,
    output logic                        fault
);
    import fetch_pkg::*;

    logic [VPN_W-1:0]     tag_q   [TLB_ENTRIES];
    logic [VPN_W-1:0]     page_q  [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] valid_q;
    logic [TLB_IDX_W-1:0] victim_q;     // Round-robin replacement pointer
    logic [VPN_W-1:0]     walk_vpn_q;
    tlb_state_e           state_q;
    logic                 match;
    logic [TLB_IDX_W-1:0] match_idx;
    logic                 pte_ok;

    always_comb begin
        match     = 1'b0;
        match_idx = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (valid_q[i] && tag_q[i] == vpn) begin
                match     = 1'b1;
                match_idx = TLB_IDX_W'(i);
            end
        end
    end

    assign hit = lookup && match;
    assign ppn = page_q[match_idx];

    // Single-level table with one word per virtual page
    assign mem.req  = (state_q == TLB_WALK);
    assign mem.addr = PT_BASE + WORD_SIZE'({walk_vpn_q, WORD_OFF_W'(0)});
    assign mem.len  = LEN_WORD;

    assign pte_ok = !mem.beat_err && mem.beat_data[PTE_VALID_BIT];
    assign fault  = (state_q == TLB_WALK) && mem.done && !pte_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= TLB_LOOKUP;
            valid_q  <= '0;
            victim_q <= '0;
        end else begin
            case (state_q)
                TLB_LOOKUP: if (lookup && !match) state_q <= TLB_WALK;
                TLB_WALK: begin
                    if (mem.done) begin
                        state_q <= TLB_LOOKUP;
                        if (pte_ok) begin
                            valid_q[victim_q] <= 1'b1;
                            victim_q          <= victim_q + 1'b1;
                        end
                    end
                end
                default: state_q <= TLB_LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == TLB_LOOKUP && lookup && !match) begin
            walk_vpn_q <= vpn; // PC may move while walking
        end
        if (state_q == TLB_WALK && mem.done && pte_ok) begin
            tag_q[victim_q]  <= walk_vpn_q;
            page_q[victim_q] <= mem.beat_data[VPN_W-1:0];
        end
    end

endmodule

// File: design/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            lookup,
    input  logic [fetch_pkg::WORD_SIZE-1:0] addr,
    mem_req_if.requester                    mem,
    output logic                            hit,
    output logic [fetch_pkg::WORD_SIZE-1:0] data,
    output logic                            fault
);
    import fetch_pkg::*;

    logic [TAG_W-1:0]     tag_q   [CACHE_LINES];
    logic [WORD_SIZE-1:0] line_q  [CACHE_LINES][LINE_WORDS];
    logic [CACHE_LINES-1:0] valid_q;

    cache_state_e         state_q;
    logic [WORD_SIZE-1:0] refill_addr_q;  // Line aligned
    logic [BEAT_W-1:0]    beat_cnt_q;
    logic                 err_seen_q;

    logic [INDEX_W-1:0]   idx;
    logic [TAG_W-1:0]     tag;
    logic [BEAT_W-1:0]    word_sel;
    logic                 tag_match;
    logic                 start_refill;
    logic [INDEX_W-1:0]   refill_idx;
    logic [TAG_W-1:0]     refill_tag;

    // Address split into tag, index and word within line
    assign idx      = addr[LINE_OFF_W +: INDEX_W];
    assign tag      = addr[WORD_SIZE-1 -: TAG_W];
    assign word_sel = addr[WORD_OFF_W +: BEAT_W];

    assign tag_match = valid_q[idx] && (tag_q[idx] == tag);
    assign hit       = lookup && tag_match;
    assign data      = line_q[idx][word_sel];

    assign start_refill = (state_q == C_IDLE) && lookup && !tag_match;

    assign refill_idx = refill_addr_q[LINE_OFF_W +: INDEX_W];
    assign refill_tag = refill_addr_q[WORD_SIZE-1 -: TAG_W];

    assign mem.req  = (state_q == C_REFILL);
    assign mem.addr = refill_addr_q;
    assign mem.len  = LEN_LINE;

    // Bus error on any beat of the line
    assign fault = (state_q == C_REFILL) && mem.beat_valid && mem.beat_err;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= C_IDLE;
            valid_q    <= '0;
            beat_cnt_q <= '0;
            err_seen_q <= 1'b0;
        end else begin
            case (state_q)
                C_IDLE: begin
                    if (start_refill) begin
                        state_q      <= C_REFILL;
                        valid_q[idx] <= 1'b0; // Victim line is overwritten
                        beat_cnt_q   <= '0;
                        err_seen_q   <= 1'b0;
                    end
                end
                C_REFILL: begin
                    if (mem.beat_valid) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (mem.beat_err) err_seen_q <= 1'b1;
                    end
                    if (mem.done) begin
                        state_q             <= C_IDLE;
                        valid_q[refill_idx] <= !err_seen_q && !mem.beat_err;
                    end
                end
                default: state_q <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_refill) begin
            refill_addr_q <= {addr[WORD_SIZE-1:LINE_OFF_W], LINE_OFF_W'(0)};
        end
        if (state_q == C_REFILL && mem.beat_valid) begin
            line_q[refill_idx][beat_cnt_q] <= mem.beat_data;
        end
        if (state_q == C_REFILL && mem.done) begin
            tag_q[refill_idx] <= refill_tag;
        end
    end

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                            clk,
    input  logic                            rst,
    mem_req_if.arbiter                      tlb_bus,
    mem_req_if.arbiter                      cache_bus,
    output logic [fetch_pkg::WORD_SIZE-1:0] paddr,
    output logic                            psel,
    output logic                            penable,
    output logic                            pwrite,
    input  logic [fetch_pkg::WORD_SIZE-1:0] prdata,
    input  logic                            pready,
    input  logic                            pslverr
);
    import fetch_pkg::*;

    arb_state_e        state_q;
    logic              gnt_tlb_q;   // TLB owns the bus
    req_len_e          len_q;
    logic [BEAT_W-1:0] beat_cnt_q;
    logic              beat;
    logic              last;
    logic              grant_tlb;
    logic              grant_cache;

    // TLB wins when both ask
    assign grant_tlb   = (state_q == ARB_IDLE) && tlb_bus.req;
    assign grant_cache = (state_q == ARB_IDLE) && !tlb_bus.req && cache_bus.req;

    assign beat = (state_q == ARB_ACCESS) && pready;
    assign last = (len_q == LEN_WORD) || (beat_cnt_q == BEAT_W'(LINE_WORDS - 1));

    assign psel    = (state_q != ARB_IDLE);
    assign penable = (state_q == ARB_ACCESS);
    assign pwrite  = 1'b0; // Read-only port

    assign tlb_bus.beat_valid   = beat && gnt_tlb_q;
    assign tlb_bus.done         = beat && gnt_tlb_q && last;
    assign tlb_bus.beat_data    = prdata;
    assign tlb_bus.beat_err     = pslverr;
    assign cache_bus.beat_valid = beat && !gnt_tlb_q;
    assign cache_bus.done       = beat && !gnt_tlb_q && last;
    assign cache_bus.beat_data  = prdata;
    assign cache_bus.beat_err   = pslverr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ARB_IDLE;
            gnt_tlb_q  <= 1'b0;
            len_q      <= LEN_WORD;
            beat_cnt_q <= '0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (grant_tlb || grant_cache) begin
                        state_q    <= ARB_SETUP;
                        gnt_tlb_q  <= grant_tlb;
                        len_q      <= grant_tlb ? tlb_bus.len : cache_bus.len;
                        beat_cnt_q <= '0;
                    end
                end
                ARB_SETUP: state_q <= ARB_ACCESS;
                ARB_ACCESS: begin
                    if (pready) begin
                        state_q    <= last ? ARB_IDLE : ARB_SETUP;
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant_tlb) begin
            paddr <= tlb_bus.addr;
        end else if (grant_cache) begin
            paddr <= cache_bus.addr;
        end else if (beat && !last) begin
            paddr <= paddr + WORD_SIZE'(WORD_BYTES); // Next word of the line
        end
    end

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            jump_taken,
    input  logic [fetch_pkg::WORD_SIZE-1:0] next_pc,
    input  logic                            exception_in,
    mem_req_if.requester                    tlb_bus,
    mem_req_if.requester                    cache_bus,
    output logic [fetch_pkg::WORD_SIZE-1:0] pc,
    output logic [fetch_pkg::WORD_SIZE-1:0] instruction,
    output logic                            valid,
    output logic                            exception
);
    import fetch_pkg::*;

    logic                 bypass;     // Exception vector is physical
    logic                 tlb_lookup;
    logic                 tlb_hit;
    logic                 tlb_fault;
    logic [VPN_W-1:0]     tlb_ppn;
    logic                 tlb_ok;
    logic [WORD_SIZE-1:0] phys_addr;
    logic                 cache_hit;
    logic                 cache_fault;
    logic                 exc_now;

    assign bypass     = (pc == PC_EXCEPTION);
    assign tlb_lookup = !exception && !bypass;
    assign tlb_ok     = bypass || tlb_hit;

    assign phys_addr = {bypass ? pc[WORD_SIZE-1 -: VPN_W] : tlb_ppn, pc[PAGE_OFFSET_W-1:0]};

    assign valid   = tlb_ok && cache_hit && !exception;
    assign exc_now = exception_in || tlb_fault || cache_fault;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= PC_INITIAL;
            exception <= 1'b0;
        end else if (exception || exc_now) begin
            pc        <= PC_EXCEPTION; // Sticky until reset
            exception <= 1'b1;
        end else if (jump_taken) begin
            pc <= next_pc;             // Wins over a stall
        end else if (valid) begin
            pc <= pc + WORD_SIZE'(WORD_BYTES);
        end
    end

    itlb itlb_i (
        .clk   (clk),
        .rst   (rst),
        .vpn   (pc[WORD_SIZE-1 -: VPN_W]),
        .lookup(tlb_lookup),
        .mem   (tlb_bus),
        .ppn   (tlb_ppn),
        .hit   (tlb_hit),
        .fault (tlb_fault)
    );

    icache icache_i (
        .clk   (clk),
        .rst   (rst),
        .lookup(!exception && tlb_ok),
        .addr  (phys_addr),
        .mem   (cache_bus),
        .hit   (cache_hit),
        .data  (instruction),
        .fault (cache_fault)
    );

endmodule

// File: design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            jump_taken,
    input  logic [fetch_pkg::WORD_SIZE-1:0] next_pc,
    input  logic                            exception_in,
    output logic [fetch_pkg::WORD_SIZE-1:0] paddr,
    output logic                            psel,
    output logic                            penable,
    output logic                            pwrite,
    input  logic [fetch_pkg::WORD_SIZE-1:0] prdata,
    input  logic                            pready,
    input  logic                            pslverr,
    output logic [fetch_pkg::WORD_SIZE-1:0] pc,
    output logic [fetch_pkg::WORD_SIZE-1:0] instruction,
    output logic                            valid,
    output logic                            exception
);

    mem_req_if tlb_bus ();   // Page-table walks
    mem_req_if cache_bus (); // Line refills

    fetch_stage fetch_stage_i (
        .clk         (clk),
        .rst         (rst),
        .jump_taken  (jump_taken),
        .next_pc     (next_pc),
        .exception_in(exception_in),
        .tlb_bus     (tlb_bus.requester),
        .cache_bus   (cache_bus.requester),
        .pc          (pc),
        .instruction (instruction),
        .valid       (valid),
        .exception   (exception)
    );

    mem_arbiter mem_arbiter_i (
        .clk      (clk),
        .rst      (rst),
        .tlb_bus  (tlb_bus.arbiter),
        .cache_bus(cache_bus.arbiter),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

endmodule

// File: tests/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
    input logic        clk,
    input logic        rst,
    input logic        jump_taken,
    input logic [31:0] next_pc,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic [31:0] pc,
    input logic [31:0] instruction,
    input logic        valid,
    input logic        exception
);
    import fetch_pkg::*;

    string       test_name = "none";
    int          error_count = 0;
    int          errors_at_start = 0;
    int          checks = 0;
    int          checks_at_start = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [31:0] expect_pc = PC_INITIAL;
    logic        rst_q = 1'b1; // Reset level at the previous falling edge

    // Page v maps to page v ^ 3 and memory returns address ^ A5A5_0000
    function automatic logic [31:0] expected_word(input logic [31:0] va);
        logic [31:0] pa;
        if (va == PC_EXCEPTION) pa = va; // Vector is never translated
        else pa = {va[31:12] ^ 20'h3, va[11:0]};
        return pa ^ 32'hA5A5_0000;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Fail %s: %s expected %h actual %h", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        checks_at_start = checks;
    endtask

    task automatic finish_test(input logic exc_expected);
        #1; // Let checks of this edge land first
        if (exception !== exc_expected) begin
            $display("Fail %s: exception expected %0b actual %0b", test_name,
                     exc_expected, exception);
            error_count++;
        end
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("Pass %s: %0d instructions checked", test_name, checks - checks_at_start);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    // Outputs and inputs are all settled at the falling edge
    always @(negedge clk) begin
        if (!rst && rst_q) begin
            check_value("pc after reset", PC_INITIAL, pc);
            check_value("valid after reset", 32'd0, {31'd0, valid});
            check_value("psel after reset", 32'd0, {31'd0, psel});
            check_value("penable after reset", 32'd0, {31'd0, penable});
            check_value("exception after reset", 32'd0, {31'd0, exception});
        end
        if (!rst) check_value("pwrite", 32'd0, {31'd0, pwrite}); // Reads only
        if (rst) begin
            expect_pc = PC_INITIAL;
        end else if (exception) begin
            check_value("held pc", PC_EXCEPTION, pc);
            check_value("valid during exception", 32'd0, {31'd0, valid});
        end else begin
            if (valid) begin
                check_value("pc", expect_pc, pc);
                check_value("instruction", expected_word(expect_pc), instruction);
                checks++;
                expect_pc = expect_pc + 32'd4;
            end
            if (jump_taken) expect_pc = next_pc; // Jump wins over the step
        end
        rst_q = rst;
    end

endmodule

// File: tests/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;
    import fetch_pkg::*;

    logic        clk;
    logic        rst;
    logic        jump_taken;
    logic [31:0] next_pc;
    logic        exception_in;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pc;
    logic [31:0] instruction;
    logic        valid;
    logic        exception;

    // Test table held as one array per column
    string       row_name    [16];
    logic        row_reset   [16];
    logic        row_jump    [16];
    logic [31:0] row_target  [16];
    int          row_count   [16];
    logic        row_exc_in  [16];
    logic        row_exc_exp [16];
    int          n_rows = 0;
    logic        table_loaded = 1'b0;

    logic [16:0] lfsr_q = 17'd79454;
    int          wait_left = 0; // Remaining APB wait states

    fetch_top dut_i (.*);

    fetch_checker chk_i (
        .clk        (clk),
        .rst        (rst),
        .jump_taken (jump_taken),
        .next_pc    (next_pc),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pc         (pc),
        .instruction(instruction),
        .valid      (valid),
        .exception  (exception)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic draw_wait(output int n);
        n = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            n = (n << 1) | lfsr_q[0];
        end
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] v;
        v = (a - PT_BASE) >> 2;
        if (a >= PT_BASE && a < PT_BASE + 32'h0040_0000)
            return {v != 32'h5, 11'd0, v[19:0] ^ 20'h3}; // PTE with page 5 marked invalid
        return a ^ 32'hA5A5_0000;
    endfunction

    task automatic serve_apb();
        if (psel && !penable) begin
            draw_wait(wait_left);
            pready  = 1'b0;
            pslverr = 1'b0;
        end else if (psel && penable && wait_left == 0) begin
            pready  = 1'b1;
            prdata  = mem_word(paddr);
            pslverr = (paddr == 32'h000F_0000);
        end else begin
            if (psel && penable) wait_left--;
            pready  = 1'b0;
            pslverr = 1'b0;
        end
    endtask

    initial begin
        forever begin
            @(posedge clk);
            #5;
            serve_apb();
        end
    end

    task automatic add_row(input string name, input logic do_reset, input logic do_jump,
                           input logic [31:0] target, input int count,
                           input logic raise_exc, input logic exc_expected);
        row_name[n_rows]    = name;
        row_reset[n_rows]   = do_reset;
        row_jump[n_rows]    = do_jump;
        row_target[n_rows]  = target;
        row_count[n_rows]   = count;
        row_exc_in[n_rows]  = raise_exc;
        row_exc_exp[n_rows] = exc_expected;
        n_rows++;
    endtask

    task automatic load_table();
        add_row("reset_sequence",  1, 0, 32'h0000_0000, 10, 0, 0);
        add_row("cached_jump",     0, 1, 32'h0000_1008,  4, 0, 0);
        add_row("line_page_cross", 0, 1, 32'h0000_2FF8,  8, 0, 0);
        add_row("page_4",          0, 1, 32'h0000_4000,  2, 0, 0);
        add_row("page_6_replace",  0, 1, 32'h0000_6000,  2, 0, 0); // Evicts page 1
        add_row("page_1_return",   0, 1, 32'h0000_1000,  4, 0, 0);
        add_row("vector_bypass",   0, 1, 32'h0000_0100,  2, 0, 0); // Untranslated then page 0
        add_row("invalid_pte",     1, 1, 32'h0000_5000,  0, 0, 1);
        add_row("exception_in",    1, 0, 32'h0000_0000,  0, 1, 1);
        add_row("bus_error",       1, 1, 32'h000F_3000,  0, 0, 1); // Maps to 000F_0000
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #5;
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #5;
        rst = 1'b0;
    endtask

    task automatic pulse_jump(input logic [31:0] target);
        @(posedge clk);
        #5;
        jump_taken = 1'b1;
        next_pc    = target;
        @(posedge clk);
        #5;
        jump_taken = 1'b0;
    endtask

    task automatic pulse_exception();
        @(posedge clk);
        #5;
        exception_in = 1'b1;
        @(posedge clk);
        #5;
        exception_in = 1'b0;
    endtask

    task automatic collect_valid(input int count);
        int seen;
        seen = 0;
        while (seen < count && !exception) begin
            @(negedge clk);
            if (valid) seen++;
        end
    endtask

    initial begin : watchdog
        int limit;
        wait (table_loaded);
        limit = 200;
        for (int i = 0; i < n_rows; i++) limit += row_count[i] * 40;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, tests did not finish", limit);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        jump_taken   = 1'b0;
        next_pc      = '0;
        exception_in = 1'b0;
        prdata       = '0;
        pready       = 1'b0;
        pslverr      = 1'b0;
        load_table();
        table_loaded = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            chk_i.start_test(row_name[r]);
            if (row_reset[r]) apply_reset();
            if (row_jump[r]) pulse_jump(row_target[r]);
            if (row_exc_in[r]) pulse_exception();
            if (row_exc_exp[r]) begin
                while (!exception) @(negedge clk);
                repeat (4) @(negedge clk); // Exception must hold
            end else begin
                collect_valid(row_count[r]);
            end
            chk_i.finish_test(row_exc_exp[r]);
        end
        $display("Tests passed %0d, failed %0d, instructions checked %0d, errors %0d",
                 chk_i.tests_passed, chk_i.tests_failed, chk_i.checks, chk_i.error_count);
        if (chk_i.error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
design/fetch_pkg.sv
design/mem_req_if.sv
design/itlb.sv
design/icache.sv
design/mem_arbiter.sv
design/fetch_stage.sv
design/fetch_top.sv
tests/fetch_checker.sv
tests/tb_fetch.sv
